/* include/frontend_consts.svh */
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// ****************************************
// Front-end widths and sizes
// ****************************************

// Instruction pointers and all jump targets.
`define IP_WIDTH 48

// Instruction window handed over by fetch.
`define INSTR_WIDTH 80

// Return-address stack entries.
`define RAS_DEPTH 4

// Cycles fetch stays held after a redirect.
`define BUBBLE_CYCLES 3

`endif

/* source/instrPkg.sv */
`default_nettype none

package instrPkg;

  // Low parcel read as a two-byte conditional jump.
  typedef struct packed {
    logic [7:0] disp;     // Signed offset in halfwords.
    logic [1:0] condHi;
    logic [3:0] opcode;
    logic [1:0] condLo;
  } shortJumpFields;

  // Low parcel read as a main opcode with its sub-function.
  typedef struct packed {
    logic [2:0] subFunc;
    logic [4:0] spare;
    logic [7:0] opcode;
  } mainFields;

  typedef union packed {
    shortJumpFields shortJump;
    mainFields      mainOp;
  } instrParcel;

  // ****************************************
  // Opcode values
  // ****************************************
  localparam logic [7:0] OPC_UNCOND = 8'd181;
  localparam logic [7:0] OPC_GROUP  = 8'd182;

  localparam logic [3:0] SHORT_JUMP_PAT    = 4'b1100;
  localparam logic [3:0] BASIC_COND_NIBBLE = 4'b1010;
  localparam logic [3:0] COND_ALWAYS       = 4'hf;  // Short form only.

  // Sub-functions of OPC_GROUP.
  localparam logic [2:0] SUB_INDIR    = 3'd0;
  localparam logic [2:0] SUB_CALL     = 3'd1;
  localparam logic [2:0] SUB_CALL_ALT = 3'd2;
  localparam logic [2:0] SUB_RET      = 3'd3;

endpackage

`default_nettype wire

/* source/jumpPkg.sv */
`default_nettype none

`include "frontend_consts.svh"

package jumpPkg;

  // One instruction as presented by the fetch source.
  typedef struct packed {
    logic [`IP_WIDTH-1:0]    ip;
    logic [`INSTR_WIDTH-1:0] instr;
    logic [3:0]              magic;        // Length code.
    logic [`IP_WIDTH-1:0]    indirTarget;  // Operand value for indirect jumps.
  } fetchBundle;

  // Decoded view of a jump.
  typedef struct packed {
    logic                        isJump;
    logic                        isCond;
    logic                        isCall;
    logic                        isRet;
    logic                        isIndir;
    logic [3:0]                  cond;
    logic signed [`IP_WIDTH-1:0] disp;  // Byte offset that is already doubled.
    logic [3:0]                  len;   // In bytes.
  } jumpInfo;

  // Fetch redirect towards the instruction cache.
  typedef struct packed {
    logic                 valid;
    logic [`IP_WIDTH-1:0] target;
  } redirect;

endpackage

`default_nettype wire

/* source/jumpDecoder.sv */
`default_nettype none

`include "frontend_consts.svh"

module jumpDecoder (
  input  logic [`INSTR_WIDTH-1:0] instr,
  input  logic [3:0]              magic,
  output jumpPkg::jumpInfo        info
);

  instrPkg::instrParcel parcel;

  logic       isShortJump;
  logic       isBasicCond;
  logic       isUncond;
  logic       isGroup;
  logic [3:0] instrLen;
  logic [3:0] shortCond;

  assign parcel = instr[15:0];

  // ****************************************
  // Instruction class
  // ****************************************

  // Short jumps only exist in the two-byte form.
  assign isShortJump = ~magic[0] &&
                       (parcel.shortJump.opcode == instrPkg::SHORT_JUMP_PAT);

  assign isBasicCond = magic[0] &&
                       (parcel.mainOp.opcode[7:4] == instrPkg::BASIC_COND_NIBBLE);

  assign isUncond = (magic[1:0] == 2'b01) &&
                    (parcel.mainOp.opcode == instrPkg::OPC_UNCOND);

  assign isGroup = magic[0] && (parcel.mainOp.opcode == instrPkg::OPC_GROUP);

  assign shortCond = {parcel.shortJump.condHi, parcel.shortJump.condLo};

  // Byte length follows from the run of ones at the bottom of magic.
  always_comb begin
    casez (magic)
      4'b???0: instrLen = 4'd2;
      4'b??01: instrLen = 4'd4;
      4'b?011: instrLen = 4'd6;
      default: instrLen = 4'd8;
    endcase
  end

  // ****************************************
  // Jump fields
  // ****************************************
  always_comb begin
    info     = '0;
    info.len = instrLen;

    if (isShortJump) begin
      info.isJump = 1'b1;
      info.cond   = shortCond;
      info.isCond = (shortCond != instrPkg::COND_ALWAYS);  // 15 is "always".
      info.disp   = {{(`IP_WIDTH-9){parcel.shortJump.disp[7]}},
                     parcel.shortJump.disp, 1'b0};
    end else if (isBasicCond) begin
      info.isJump = 1'b1;
      info.isCond = 1'b1;
      // The top condition bit moves with the encoding length.
      info.cond   = {(magic[1:0] == 2'b01) ? instr[18] : instr[32],
                     parcel.mainOp.opcode[3:1]};
      if (magic[1:0] == 2'b01) begin
        info.disp = {{(`IP_WIDTH-14){instr[31]}}, instr[31:19], 1'b0};
      end else if (magic[2:0] == 3'b011) begin
        info.disp = {{(`IP_WIDTH-16){instr[47]}}, instr[47:33], 1'b0};
      end else begin
        info.disp = {{(`IP_WIDTH-32){instr[63]}}, instr[63:33], 1'b0};
      end
    end else if (isUncond) begin
      info.isJump = 1'b1;
      info.disp   = {{(`IP_WIDTH-25){instr[31]}}, instr[31:8], 1'b0};
    end else if (isGroup) begin
      case (parcel.mainOp.subFunc)
        instrPkg::SUB_INDIR: begin
          info.isJump  = 1'b1;
          info.isIndir = 1'b1;
        end
        instrPkg::SUB_CALL,
        instrPkg::SUB_CALL_ALT: begin
          info.isJump = 1'b1;
          info.isCall = 1'b1;
          info.disp   = {{(`IP_WIDTH-17){instr[31]}}, instr[31:16], 1'b0};
        end
        instrPkg::SUB_RET: begin
          info.isJump = 1'b1;
          info.isRet  = 1'b1;
        end
        default: info.isJump = 1'b0;  // Rest of the group is not control flow.
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/returnStack.sv */
`default_nettype none

`include "frontend_consts.svh"

module returnStack (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 push,
  input  logic                 pop,
  input  logic [`IP_WIDTH-1:0] pushAddr,
  output logic [`IP_WIDTH-1:0] top,
  output logic                 empty
);

  localparam int PTR_W = (`RAS_DEPTH > 1) ? $clog2(`RAS_DEPTH) : 1;
  localparam int CNT_W = $clog2(`RAS_DEPTH + 1);

  logic [`IP_WIDTH-1:0] entries [`RAS_DEPTH];
  logic [PTR_W-1:0]     topPtr;   // Slot of the most recent push.
  logic [PTR_W-1:0]     nextPtr;
  logic [PTR_W-1:0]     prevPtr;
  logic [CNT_W-1:0]     fill;

  assign nextPtr = (topPtr == PTR_W'(`RAS_DEPTH - 1)) ? '0 : topPtr + 1'b1;
  assign prevPtr = (topPtr == '0) ? PTR_W'(`RAS_DEPTH - 1) : topPtr - 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      topPtr <= '0;
      fill   <= '0;
    end else if (push) begin
      topPtr <= nextPtr;
      // When full the oldest entry is lost, so the count saturates.
      if (fill != CNT_W'(`RAS_DEPTH)) fill <= fill + 1'b1;
    end else if (pop && !empty) begin
      topPtr <= prevPtr;
      fill   <= fill - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) entries[nextPtr] <= pushAddr;
  end

  assign top   = entries[topPtr];
  assign empty = (fill == '0);

  aPushPopExclusive: assert property (@(posedge clk) disable iff (reset) !(push && pop));

endmodule

`default_nettype wire

/* source/targetCalc.sv */
`default_nettype none

`include "frontend_consts.svh"

module targetCalc (
  input  jumpPkg::jumpInfo     info,
  input  logic [`IP_WIDTH-1:0] ip,
  input  logic [`IP_WIDTH-1:0] indirTarget,
  input  logic [`IP_WIDTH-1:0] rasTop,
  input  logic                 rasEmpty,
  output logic                 taken,
  output logic [`IP_WIDTH-1:0] target
);

  logic [`IP_WIDTH-1:0] relTarget;

  assign relTarget = ip + info.disp;

  // Static prediction. Backward conditional jumps are loops, so take them.
  always_comb begin
    if (!info.isJump) begin
      taken = 1'b0;
    end else if (info.isCond) begin
      taken = info.disp[`IP_WIDTH-1];
    end else if (info.isRet) begin
      taken = !rasEmpty;  // Nothing to return to otherwise.
    end else begin
      taken = 1'b1;
    end
  end

  always_comb begin
    if (info.isRet) begin
      target = rasTop;
    end else if (info.isIndir) begin
      target = indirTarget;
    end else begin
      target = relTarget;
    end
  end

endmodule

`default_nettype wire

/* source/bubbleTimer.sv */
`default_nettype none

`include "frontend_consts.svh"

module bubbleTimer (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic done
);

  localparam int CNT_W = $clog2(`BUBBLE_CYCLES + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (start) begin
      count <= CNT_W'(`BUBBLE_CYCLES);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // Done marks the last bubble cycle so that the sequencer can leave on this edge.
  assign done = (count == CNT_W'(1));

  aNoRestart: assert property (@(posedge clk) disable iff (reset) start |-> (count == '0));

endmodule

`default_nettype wire

/* source/fetchSequencer.sv */
`default_nettype none

`include "frontend_consts.svh"

module fetchSequencer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 instrValid,
  input  jumpPkg::fetchBundle  bundle,
  input  jumpPkg::jumpInfo     info,
  input  logic                 taken,
  input  logic [`IP_WIDTH-1:0] target,
  input  logic                 timerDone,
  output jumpPkg::fetchBundle  held,
  output logic                 push,
  output logic                 pop,
  output logic [`IP_WIDTH-1:0] pushAddr,
  output logic                 timerStart,
  output logic                 busy,
  output jumpPkg::redirect     redir
);

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    RESOLVE = 2'd1,
    BUBBLE  = 2'd2
  } seqState;

  seqState              state;
  logic                 redirValid;
  logic [`IP_WIDTH-1:0] redirTarget;

  // ****************************************
  // Control
  // ****************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      redirValid <= 1'b0;
    end else begin
      redirValid <= 1'b0;
      case (state)
        IDLE:    if (instrValid) state <= RESOLVE;
        RESOLVE: begin
          redirValid <= taken;
          state      <= taken ? BUBBLE : IDLE;
        end
        BUBBLE:  if (timerDone) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && instrValid) held <= bundle;
    if (state == RESOLVE) redirTarget <= target;
  end

  assign busy       = (state != IDLE);
  assign timerStart = (state == RESOLVE) && taken;

  // Stack updates land on the resolve edge.
  assign push     = (state == RESOLVE) && info.isCall;
  assign pop      = (state == RESOLVE) && info.isRet && taken;
  assign pushAddr = held.ip + `IP_WIDTH'(info.len);  // Address after the call.

  assign redir.valid  = redirValid;
  assign redir.target = redirTarget;

  aNoStrobeWhileBusy: assert property (@(posedge clk) disable iff (reset)
    instrValid |-> !busy);

  aLegalState: assert property (@(posedge clk) disable iff (reset)
    state inside {IDLE, RESOLVE, BUBBLE});

endmodule

`default_nettype wire

/* source/branchFrontend.sv */
`default_nettype none

`include "frontend_consts.svh"

module branchFrontend (
  input  logic                clk,
  input  logic                reset,
  input  logic                instrValid,
  input  jumpPkg::fetchBundle bundle,
  output logic                busy,
  output jumpPkg::redirect    redir
);

  jumpPkg::fetchBundle  held;
  jumpPkg::jumpInfo     info;
  logic                 taken;
  logic [`IP_WIDTH-1:0] target;
  logic [`IP_WIDTH-1:0] rasTop;
  logic                 rasEmpty;
  logic                 push;
  logic                 pop;
  logic [`IP_WIDTH-1:0] pushAddr;
  logic                 timerStart;
  logic                 timerDone;

  fetchSequencer u_sequencer (
    .clk        (clk),
    .reset      (reset),
    .instrValid (instrValid),
    .bundle     (bundle),
    .info       (info),
    .taken      (taken),
    .target     (target),
    .timerDone  (timerDone),
    .held       (held),
    .push       (push),
    .pop        (pop),
    .pushAddr   (pushAddr),
    .timerStart (timerStart),
    .busy       (busy),
    .redir      (redir)
  );

  // Decode works on the captured copy, not the live bus.
  jumpDecoder u_decoder (
    .instr (held.instr),
    .magic (held.magic),
    .info  (info)
  );

  targetCalc u_target (
    .info        (info),
    .ip          (held.ip),
    .indirTarget (held.indirTarget),
    .rasTop      (rasTop),
    .rasEmpty    (rasEmpty),
    .taken       (taken),
    .target      (target)
  );

  returnStack u_ras (
    .clk      (clk),
    .reset    (reset),
    .push     (push),
    .pop      (pop),
    .pushAddr (pushAddr),
    .top      (rasTop),
    .empty    (rasEmpty)
  );

  bubbleTimer u_bubble (
    .clk   (clk),
    .reset (reset),
    .start (timerStart),
    .done  (timerDone)
  );

endmodule

`default_nettype wire

/* test/branchFrontendTb.sv */
`default_nettype none

`include "frontend_consts.svh"

module branchFrontendTb;

  localparam int WAIT_LIMIT  = 64;
  localparam int RANDOM_ROWS = 24;

  typedef struct packed {
    jumpPkg::fetchBundle  bundle;
    logic                 expTaken;
    logic [`IP_WIDTH-1:0] expTarget;
  } testRow;

  logic                clk;
  logic                reset;
  logic                instrValid;
  jumpPkg::fetchBundle bundle;
  logic                busy;
  jumpPkg::redirect    redir;

  testRow               rows[$];
  logic [`IP_WIDTH-1:0] modelStack[$];  // Newest entry at the back.
  logic [31:0]          lcgState;
  int                   currentRow;

  branchFrontend u_dut (
    .clk        (clk),
    .reset      (reset),
    .instrValid (instrValid),
    .bundle     (bundle),
    .busy       (busy),
    .redir      (redir)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Sign-extends a displacement field of the given width and scales it to bytes.
  function automatic logic [`IP_WIDTH-1:0] byteDisp(input logic [31:0] field, input int width);
    logic signed [`IP_WIDTH-1:0] wide;
    wide = `IP_WIDTH'(field) << (`IP_WIDTH - width);
    wide = wide >>> (`IP_WIDTH - width);
    return wide <<< 1;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] row %0d %s: got %h, expected %h", currentRow, name, actual, expected);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  // ****************************************
  // Stimulus table
  // ****************************************
  task automatic addRow(input logic [`INSTR_WIDTH-1:0] instr, input logic [3:0] magic,
                        input logic [`IP_WIDTH-1:0] ip, input logic [`IP_WIDTH-1:0] indir,
                        input logic taken, input logic [`IP_WIDTH-1:0] target);
    testRow row;
    row.bundle.ip          = ip;
    row.bundle.instr       = instr;
    row.bundle.magic       = magic;
    row.bundle.indirTarget = indir;
    row.expTaken           = taken;
    row.expTarget          = taken ? target : '0;
    rows.push_back(row);
  endtask

  task automatic addShort(input logic [`IP_WIDTH-1:0] ip, input logic [3:0] cond,
                          input logic [7:0] disp);
    logic [`INSTR_WIDTH-1:0] instr;
    instr = '0;
    instr[15:0] = {disp, cond[3:2], 4'b1100, cond[1:0]};
    addRow(instr, 4'b0000, ip, '0, (cond == 4'hf) || disp[7], ip + byteDisp(disp, 8));
  endtask

  // A basic conditional jump is taken only when it points backward.
  task automatic addBasic(input logic [`IP_WIDTH-1:0] ip, input logic [3:0] magic,
                          input logic [31:0] disp);
    logic [`INSTR_WIDTH-1:0] instr;
    logic [`IP_WIDTH-1:0]    offset;
    instr = '0;
    instr[7:0] = 8'b1010_1010;
    case (magic)
      4'b0001: begin
        instr[18]    = 1'b1;
        instr[31:19] = disp[12:0];
        offset       = byteDisp(disp, 13);
      end
      4'b0011: begin
        instr[32]    = 1'b1;
        instr[47:33] = disp[14:0];
        offset       = byteDisp(disp, 15);
      end
      default: begin
        instr[63:33] = disp[30:0];
        offset       = byteDisp(disp, 31);
      end
    endcase
    addRow(instr, magic, ip, '0, offset[`IP_WIDTH-1], ip + offset);
  endtask

  task automatic addUncond(input logic [`IP_WIDTH-1:0] ip, input logic [23:0] disp);
    logic [`INSTR_WIDTH-1:0] instr;
    instr = '0;
    instr[31:0] = {disp, 8'd181};
    addRow(instr, 4'b0001, ip, '0, 1'b1, ip + byteDisp(disp, 24));
  endtask

  // Indirect jumps, calls and returns of the group opcode keep the model stack in step.
  task automatic addGroup(input logic [`IP_WIDTH-1:0] ip, input logic [3:0] magic,
                          input logic [3:0] len, input logic [2:0] sub,
                          input logic [15:0] disp, input logic [`IP_WIDTH-1:0] indir);
    logic [`INSTR_WIDTH-1:0] instr;
    instr = '0;
    instr[31:0] = {disp, sub, 5'b0, 8'd182};
    if (sub == 3'd0) begin
      addRow(instr, magic, ip, indir, 1'b1, indir);
    end else if (sub == 3'd1 || sub == 3'd2) begin
      modelStack.push_back(ip + len);
      if (modelStack.size() > `RAS_DEPTH) void'(modelStack.pop_front());  // Oldest is lost.
      addRow(instr, magic, ip, indir, 1'b1, ip + byteDisp(disp, 16));
    end else if (sub == 3'd3 && modelStack.size() > 0) begin
      addRow(instr, magic, ip, indir, 1'b1, modelStack.pop_back());
    end else begin
      addRow(instr, magic, ip, indir, 1'b0, '0);
    end
  endtask

  task automatic buildTable();
    logic [31:0]          hi;
    logic [31:0]          lo;
    logic [31:0]          d;
    logic [`IP_WIDTH-1:0] ip;
    addGroup(48'h0000_1000_0000, 4'b0001, 4'd4, 3'd3, '0, '0);  // Return on an empty stack.
    addShort(48'h0000_0040_1000, 4'h3, 8'hf0);
    addShort(48'h0000_0040_1000, 4'h3, 8'h20);
    addShort(48'h0000_0040_2000, 4'hf, 8'h10);
    addShort(48'h0000_0040_2000, 4'hf, 8'h80);
    addBasic(48'h1234_0000_0100, 4'b0001, 32'h1ff0);
    addBasic(48'h1234_0000_0100, 4'b0001, 32'h0040);
    addBasic(48'h1234_0000_0200, 4'b0011, 32'h7000);
    addBasic(48'h1234_0000_0200, 4'b0011, 32'h0123);
    addBasic(48'h1234_0000_0300, 4'b0111, 32'h7fff_fff0);
    addBasic(48'h1234_0000_0300, 4'b0111, 32'h0000_1000);
    addUncond(48'h0000_8000_0000, 24'hfff800);
    addUncond(48'h0000_8000_0000, 24'h000400);
    addGroup(48'h0000_9000_0000, 4'b0001, 4'd4, 3'd0, '0, 48'h7654_3210_abcd);
    addGroup(48'h0000_a000_0000, 4'b0001, 4'd4, 3'd1, 16'h0100, '0);
    addGroup(48'h0000_a000_1000, 4'b0001, 4'd4, 3'd3, '0, '0);
    // More calls than stack entries, then unwind past the bottom.
    for (int i = 0; i < `RAS_DEPTH + 2; i++) begin
      addGroup(48'h0000_b000_0000 + 48'(i * 'h40), i[0] ? 4'b0011 : 4'b0001,
               i[0] ? 4'd6 : 4'd4, i[0] ? 3'd2 : 3'd1, 16'hff00 + 16'(i), '0);
    end
    for (int i = 0; i < `RAS_DEPTH + 2; i++) begin
      addGroup(48'h0000_c000_0000, 4'b0001, 4'd4, 3'd3, '0, '0);
    end
    addRow(80'hb5, 4'b0000, 48'h0000_d000_0000, '0, 1'b0, '0);
    addRow(80'ha4, 4'b0000, 48'h0000_d000_0002, '0, 1'b0, '0);
    addRow(80'h12, 4'b0001, 48'h0000_d000_0004, '0, 1'b0, '0);
    addGroup(48'h0000_d000_0008, 4'b0001, 4'd4, 3'd5, 16'h0010, '0);
    for (int i = 0; i < RANDOM_ROWS; i++) begin
      hi = nextRand();
      lo = nextRand();
      d  = nextRand();
      ip = {hi[15:0], lo};
      case (hi[31:29] % 5)
        0: addShort(ip, d[11:8], d[7:0]);
        1: addBasic(ip, 4'b0001, d);
        2: addBasic(ip, 4'b0011, d);
        3: addBasic(ip, 4'b0111, d);
        default: addUncond(ip, d[23:0]);
      endcase
    end
  endtask

  // Strobe one instruction and follow it until fetch is released.
  task automatic applyRow(input testRow row);
    int                   cycles;
    int                   redirCount;
    logic [`IP_WIDTH-1:0] seenTarget;
    cycles     = 0;
    redirCount = 0;
    seenTarget = '0;
    @(posedge clk);
    instrValid <= 1'b1;
    bundle     <= row.bundle;
    @(posedge clk);
    instrValid <= 1'b0;
    @(negedge clk);
    checkValue("busy", busy, 1);
    while (busy) begin
      if (redir.valid) begin
        redirCount++;
        seenTarget = redir.target;
      end
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("Row %0d: busy never dropped after the instruction", currentRow);
        $display("Some tests failed");
        $fatal(1);
      end
      @(negedge clk);
    end
    checkValue("redirect count", redirCount, row.expTaken);
    if (row.expTaken) checkValue("redir.target", seenTarget, row.expTarget);
    checkValue("busy cycles", cycles, row.expTaken ? 1 + `BUBBLE_CYCLES : 1);
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    instrValid = 1'b0;
    bundle     = '0;
    lcgState   = 32'h35155836;
    currentRow = -1;
    buildTable();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkValue("busy", busy, 0);
    checkValue("redir.valid", redir.valid, 0);
    foreach (rows[i]) begin
      currentRow = i;
      applyRow(rows[i]);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
source/instrPkg.sv
source/jumpPkg.sv
source/jumpDecoder.sv
source/returnStack.sv
source/targetCalc.sv
source/bubbleTimer.sv
source/fetchSequencer.sv
source/branchFrontend.sv
test/branchFrontendTb.sv
